//--- id_config.svh
// id stage configuration: datapath widths and the flush instruction

`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// data and pc width
`define XLEN        32
// instruction width
`define INST_WD     32

// general purpose registers
`define GPR_ADDR_WD 5
`define GPR_NUM     32

// addi x0, x0, 0
`define NOP_INST    32'h0000_0013

`endif

//--- id_pkg.sv
// id stage types: opcode enum and the buses between pipeline stages

`include "id_config.svh"

package id_pkg;

  // decoded rv32i subset
  typedef enum logic [3:0] {
    OP_LUI     = 4'd0,
    OP_ADDI    = 4'd1,
    OP_ADD     = 4'd2,
    OP_SUB     = 4'd3,
    OP_LW      = 4'd4,
    OP_SW      = 4'd5,
    OP_BEQ     = 4'd6,
    OP_BNE     = 4'd7,
    OP_BLT     = 4'd8,
    OP_BGE     = 4'd9,
    OP_JAL     = 4'd10,
    OP_JALR    = 4'd11,
    OP_INVALID = 4'd15
  } op_e;

  // fetch to decode
  typedef struct packed {
    logic [`INST_WD-1:0] inst;
    logic [`XLEN-1:0]    pc;
  } fs_to_ds_t;

  // decode to execute
  typedef struct packed {
    op_e                    op;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                   gpr_wen;
    logic                   load_sel;  // execute reports this back for load-use
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       pc;
  } ds_to_es_t;

  // write back to register file
  typedef struct packed {
    logic                    wen;
    logic [`GPR_ADDR_WD-1:0] waddr;
    logic [`XLEN-1:0]        wdata;
  } gpr_wr_t;

  // result from a later stage, rd of 0 means nothing to forward
  typedef struct packed {
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]        result;
  } bypass_t;

  // redirect to fetch
  typedef struct packed {
    logic             taken;
    logic [`XLEN-1:0] target;
  } br_bus_t;

endpackage

//--- id_latch.sv
// id stage latch: holds the fetched instruction and valid bit, builds allowin

`include "id_config.svh"

module id_latch
  import id_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_arst_n,
  input  logic      i_fs_valid,
  input  fs_to_ds_t i_fs_bus,
  input  logic      i_flush,      // taken branch handing off this cycle
  input  logic      i_ready_go,
  input  logic      i_es_allowin,
  output logic      o_ds_allowin,
  output logic      o_ds_valid,
  output fs_to_ds_t o_ds_bus
);

  logic      ds_valid;
  fs_to_ds_t ds_bus;
  logic      capture;

  assign o_ds_allowin = !ds_valid || (i_ready_go && i_es_allowin);
  assign capture      = i_fs_valid && o_ds_allowin;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  // wrong-path instruction becomes a nop, pc kept
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_bus <= '0;
    end else if (capture) begin
      ds_bus.inst <= i_flush ? `NOP_INST : i_fs_bus.inst;
      ds_bus.pc   <= i_fs_bus.pc;
    end
  end

  assign o_ds_valid = ds_valid;
  assign o_ds_bus   = ds_bus;

endmodule

//--- id_decoder.sv
// rv32i subset decoder: field extraction, immediates and opcode class

`include "id_config.svh"

module id_decoder
  import id_pkg::*;
(
  input  logic [`INST_WD-1:0]     i_inst,
  output logic [`GPR_ADDR_WD-1:0] o_rs1,
  output logic [`GPR_ADDR_WD-1:0] o_rs2,
  output op_e                     o_op,
  output logic [`GPR_ADDR_WD-1:0] o_rd,
  output logic [`XLEN-1:0]        o_imm,
  output logic                    o_gpr_wen,
  output logic                    o_load_sel
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_op = OP_INVALID;
    case (opcode)
      OPC_LUI:    o_op = OP_LUI;
      OPC_OPIMM:  if (funct3 == 3'b000) o_op = OP_ADDI;
      OPC_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) o_op = OP_ADD;
        else if (funct3 == 3'b000 && funct7 == 7'b0100000) o_op = OP_SUB;
      end
      OPC_LOAD:   if (funct3 == 3'b010) o_op = OP_LW;
      OPC_STORE:  if (funct3 == 3'b010) o_op = OP_SW;
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  o_op = OP_BEQ;
          3'b001:  o_op = OP_BNE;
          3'b100:  o_op = OP_BLT;
          3'b101:  o_op = OP_BGE;
          default: o_op = OP_INVALID;
        endcase
      end
      OPC_JAL:    o_op = OP_JAL;
      OPC_JALR:   if (funct3 == 3'b000) o_op = OP_JALR;
      default:    o_op = OP_INVALID;
    endcase
  end

  // immediate format and write enable follow the op
  always_comb begin
    o_imm     = '0;
    o_gpr_wen = 1'b0;
    case (o_op)
      OP_LUI:                        begin o_imm = imm_u; o_gpr_wen = 1'b1; end
      OP_ADDI, OP_LW, OP_JALR:       begin o_imm = imm_i; o_gpr_wen = 1'b1; end
      OP_ADD, OP_SUB:                o_gpr_wen = 1'b1;  // register operands only
      OP_SW:                         o_imm = imm_s;
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE: o_imm = imm_b;
      OP_JAL:                        begin o_imm = imm_j; o_gpr_wen = 1'b1; end
      default:                       o_imm = '0;
    endcase
  end

  assign o_rs1      = i_inst[19:15];
  assign o_rs2      = i_inst[24:20];
  assign o_rd       = o_gpr_wen ? i_inst[11:7] : '0;  // no dest for store, branch
  assign o_load_sel = (o_op == OP_LW);

endmodule

//--- id_gpr.sv
// general purpose register file: 2 read ports, 1 write port, x0 hardwired

`include "id_config.svh"

module id_gpr
  import id_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic [`GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [`GPR_ADDR_WD-1:0] i_raddr2,
  output logic [`XLEN-1:0]        o_rdata1,
  output logic [`XLEN-1:0]        o_rdata2,
  input  gpr_wr_t                 i_wr
);

  logic [`XLEN-1:0] regs [`GPR_NUM];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.wen && i_wr.waddr != '0) begin  // x0 stays zero
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  // same-cycle write is covered by the ws bypass
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- id_operand_bypass.sv
// operand forwarding from es, ms and ws, and load-use hazard detection

`include "id_config.svh"

module id_operand_bypass
  import id_pkg::*;
(
  input  logic [`GPR_ADDR_WD-1:0] i_rs1,
  input  logic [`GPR_ADDR_WD-1:0] i_rs2,
  input  logic [`XLEN-1:0]        i_rdata1,
  input  logic [`XLEN-1:0]        i_rdata2,
  input  bypass_t                 i_es_bypass,
  input  bypass_t                 i_ms_bypass,
  input  bypass_t                 i_ws_bypass,
  input  logic                    i_es_load,    // es holds a load, result not ready
  output logic [`XLEN-1:0]        o_rs1_data,
  output logic [`XLEN-1:0]        o_rs2_data,
  output logic                    o_load_stall
);

  function automatic logic hit(input bypass_t byp, input logic [`GPR_ADDR_WD-1:0] src);
    return (byp.rd != '0) && (byp.rd == src);
  endfunction

  // youngest stage wins
  function automatic logic [`XLEN-1:0] fwd(input logic [`GPR_ADDR_WD-1:0] src,
                                            input logic [`XLEN-1:0] rf_data);
    logic [`XLEN-1:0] data;
    data = rf_data;
    if (hit(i_ws_bypass, src)) data = i_ws_bypass.result;
    if (hit(i_ms_bypass, src)) data = i_ms_bypass.result;
    if (hit(i_es_bypass, src)) data = i_es_bypass.result;
    return data;
  endfunction

  assign o_rs1_data = fwd(i_rs1, i_rdata1);
  assign o_rs2_data = fwd(i_rs2, i_rdata2);

  // wait until the load reaches mem stage
  assign o_load_stall = i_es_load && (hit(i_es_bypass, i_rs1) || hit(i_es_bypass, i_rs2));

endmodule

//--- id_branch_unit.sv
// branch unit: compare, target computation and taken decision

`include "id_config.svh"

module id_branch_unit
  import id_pkg::*;
(
  input  op_e              i_op,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [`XLEN-1:0] i_imm,
  input  logic [`XLEN-1:0] i_rs1_data,
  input  logic [`XLEN-1:0] i_rs2_data,
  output br_bus_t          o_br
);

  logic             eq;
  logic             lt;
  logic [`XLEN-1:0] pc_target;
  logic [`XLEN-1:0] reg_target;

  assign eq         = (i_rs1_data == i_rs2_data);
  assign lt         = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign pc_target  = i_pc + i_imm;
  assign reg_target = i_rs1_data + i_imm;

  always_comb begin
    o_br.taken  = 1'b0;
    o_br.target = pc_target;
    case (i_op)
      OP_BEQ:  o_br.taken = eq;
      OP_BNE:  o_br.taken = !eq;
      OP_BLT:  o_br.taken = lt;
      OP_BGE:  o_br.taken = !lt;
      OP_JAL:  o_br.taken = 1'b1;
      OP_JALR: begin
        o_br.taken  = 1'b1;
        o_br.target = {reg_target[`XLEN-1:1], 1'b0};  // lsb cleared
      end
      default: o_br.taken = 1'b0;
    endcase
  end

endmodule

//--- id_stage.sv
// instruction decode stage: latch, decode, register read, forwarding and branch

`include "id_config.svh"

module id_stage
  import id_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_arst_n,
  // fetch side
  input  logic      i_fs_valid,
  input  fs_to_ds_t i_fs_bus,
  output logic      o_ds_allowin,
  // execute side
  input  logic      i_es_allowin,
  output logic      o_ds_to_es_valid,
  output ds_to_es_t o_ds_to_es_bus,
  output br_bus_t   o_br_bus,
  // write back and forwarding
  input  gpr_wr_t   i_wb,
  input  logic      i_es_load,
  input  bypass_t   i_es_bypass,
  input  bypass_t   i_ms_bypass,
  input  bypass_t   i_ws_bypass
);

  logic                    ds_valid;
  fs_to_ds_t               ds_bus;
  logic                    load_stall;
  logic                    ready_go;
  logic                    handoff;
  logic [`GPR_ADDR_WD-1:0] rs1, rs2, rd;
  logic [`XLEN-1:0]        rdata1, rdata2, rs1_data, rs2_data, imm;
  op_e                     op;
  logic                    gpr_wen, load_sel;
  br_bus_t                 br;

  assign ready_go         = !load_stall;
  assign o_ds_to_es_valid = ds_valid && ready_go;
  assign handoff          = o_ds_to_es_valid && i_es_allowin;

  id_latch u_latch (
    .i_clk, .i_arst_n, .i_fs_valid, .i_fs_bus,
    .i_flush      (o_br_bus.taken),
    .i_ready_go   (ready_go),
    .i_es_allowin,
    .o_ds_allowin,
    .o_ds_valid   (ds_valid),
    .o_ds_bus     (ds_bus)
  );

  id_decoder u_decoder (
    .i_inst (ds_bus.inst), .o_rs1 (rs1), .o_rs2 (rs2), .o_op (op),
    .o_rd (rd), .o_imm (imm), .o_gpr_wen (gpr_wen), .o_load_sel (load_sel)
  );

  id_gpr u_gpr (
    .i_clk, .i_arst_n, .i_raddr1 (rs1), .i_raddr2 (rs2),
    .o_rdata1 (rdata1), .o_rdata2 (rdata2), .i_wr (i_wb)
  );

  id_operand_bypass u_bypass (
    .i_rs1 (rs1), .i_rs2 (rs2), .i_rdata1 (rdata1), .i_rdata2 (rdata2),
    .i_es_bypass, .i_ms_bypass, .i_ws_bypass, .i_es_load,
    .o_rs1_data (rs1_data), .o_rs2_data (rs2_data), .o_load_stall (load_stall)
  );

  id_branch_unit u_bru (
    .i_op (op), .i_pc (ds_bus.pc), .i_imm (imm),
    .i_rs1_data (rs1_data), .i_rs2_data (rs2_data), .o_br (br)
  );

  // redirect only when the branch actually leaves decode
  assign o_br_bus.taken  = br.taken && handoff;
  assign o_br_bus.target = br.target;

  assign o_ds_to_es_bus = '{op: op, rd: rd, gpr_wen: gpr_wen, load_sel: load_sel,
                            rs1_data: rs1_data, rs2_data: rs2_data,
                            imm: imm, pc: ds_bus.pc};

endmodule

//--- id_checker.sv
// id stage checker: compares dut ports with expected values every cycle

module id_checker
  import id_pkg::*;
(
  input logic      i_clk,
  input logic      i_arst_n,
  input logic      i_ds_allowin,
  input logic      i_ds_to_es_valid,
  input ds_to_es_t i_ds_to_es_bus,
  input br_bus_t   i_br_bus,
  input logic      i_exp_allowin,
  input logic      i_exp_valid,
  input logic      i_exp_bus_en,   // latch full in the model
  input ds_to_es_t i_exp_bus,
  input br_bus_t   i_exp_br
);

  timeunit 1ns;
  timeprecision 1ps;

  string cur_name = "reset";
  int    test_errs;
  int    test_checks;
  int    err_total;
  int    tests_run;
  int    tests_failed;

  task automatic flag(input string field, input logic [159:0] e, input logic [159:0] a);
    $display("CHECK FAILED %s %s expected %0h actual %0h", cur_name, field, e, a);
    test_errs++;
    err_total++;
  endtask

  always @(posedge i_clk) begin
    if (i_arst_n) begin
      test_checks++;
      if (i_ds_allowin !== i_exp_allowin) flag("allowin", i_exp_allowin, i_ds_allowin);
      if (i_ds_to_es_valid !== i_exp_valid) flag("valid", i_exp_valid, i_ds_to_es_valid);
      if (i_exp_bus_en && i_ds_to_es_bus !== i_exp_bus)
        flag("ds_to_es_bus", i_exp_bus, i_ds_to_es_bus);
      if (i_br_bus.taken !== i_exp_br.taken) flag("br_taken", i_exp_br.taken, i_br_bus.taken);
      else if (i_exp_br.taken && i_br_bus.target !== i_exp_br.target)
        flag("br_target", i_exp_br.target, i_br_bus.target);
    end
  end

  task automatic start_test(input string name);
    cur_name    = name;
    test_errs   = 0;
    test_checks = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %-12s %s  (%0d cycles, %0d errors)", cur_name,
             (test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
  endtask

  task automatic print_totals();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
  endtask

endmodule

//--- id_stage_assert.sv
// id stage assertions: stall hold, flush after a taken branch, clean reset

`include "id_config.svh"

module id_stage_assert
  import id_pkg::*;
(
  input logic      i_clk,
  input logic      i_arst_n,
  input logic      i_fs_valid,
  input fs_to_ds_t i_fs_bus,
  input logic      load_stall,
  input logic      ds_valid,
  input fs_to_ds_t ds_bus,
  input logic      o_ds_allowin,
  input logic      o_ds_to_es_valid,
  input br_bus_t   o_br_bus
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // stalled instruction stays put in the latch
  a_hold_in_stall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (load_stall && ds_valid) |-> (!o_ds_to_es_valid && !o_ds_allowin)
      ##1 (ds_valid && $stable(ds_bus)))
    else begin
      $error("load-use stall did not hold the instruction in decode");
      fail_count++;
    end

  // fetched instruction behind a taken branch turns into a nop
  a_flush_on_taken: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_br_bus.taken && i_fs_valid) |=>
      (ds_valid && ds_bus.inst == `NOP_INST && ds_bus.pc == $past(i_fs_bus.pc)))
    else begin
      $error("instruction after a taken branch was not replaced by a nop");
      fail_count++;
    end

  // first edge after reset release
  a_empty_after_reset: assert property (@(posedge i_clk) $rose(i_arst_n) |-> !ds_valid)
    else begin
      $error("latch not empty after reset");
      fail_count++;
    end

endmodule

bind id_stage id_stage_assert u_assert (.*);

//--- tb_id_stage.sv
// id stage testbench: random rv32i stream, latch and register model, checker

`include "id_config.svh"

module tb_id_stage
  import id_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CYCLES   = 300;  // per test
  localparam int N_TESTS  = 6;
  localparam int PERIOD   = 40;

  typedef struct packed {
    ds_to_es_t bus;
    br_bus_t   br;
    logic      stall;
  } ref_t;

  logic      i_clk = 1'b0;
  logic      i_arst_n;
  logic      i_fs_valid, i_es_allowin, i_es_load;
  fs_to_ds_t i_fs_bus;
  gpr_wr_t   i_wb;
  bypass_t   i_es_bypass, i_ms_bypass, i_ws_bypass;
  logic      o_ds_allowin, o_ds_to_es_valid;
  ds_to_es_t o_ds_to_es_bus;
  br_bus_t   o_br_bus;

  logic      exp_allowin, exp_valid, exp_bus_en;
  ds_to_es_t exp_bus;
  br_bus_t   exp_br;

  logic [31:0] x = 32'd83574;
  logic [31:0] shadow [32];
  logic        m_valid, pend_have;
  fs_to_ds_t   m_bus, pend;
  logic [31:0] next_pc;

  always #(PERIOD/2) i_clk = ~i_clk;

  id_stage u_dut (.*);

  id_checker u_chk (
    .i_clk, .i_arst_n, .i_ds_allowin (o_ds_allowin), .i_ds_to_es_valid (o_ds_to_es_valid),
    .i_ds_to_es_bus (o_ds_to_es_bus), .i_br_bus (o_br_bus),
    .i_exp_allowin (exp_allowin), .i_exp_valid (exp_valid), .i_exp_bus_en (exp_bus_en),
    .i_exp_bus (exp_bus), .i_exp_br (exp_br)
  );

  function automatic logic [31:0] rnd();
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] operand(input logic [4:0] s);
    if (i_es_bypass.rd != 0 && i_es_bypass.rd == s) return i_es_bypass.result;
    if (i_ms_bypass.rd != 0 && i_ms_bypass.rd == s) return i_ms_bypass.result;
    if (i_ws_bypass.rd != 0 && i_ws_bypass.rd == s) return i_ws_bypass.result;
    return (s == 0) ? 32'd0 : shadow[s];
  endfunction

  // expected bus, redirect and stall from the isa rules
  function automatic ref_t ref_model(input logic [31:0] inst, input logic [31:0] pc);
    ref_t        r;
    logic [2:0]  f3;
    logic [31:0] a, b, ii;
    r = '0;
    r.bus.op = OP_INVALID;
    f3 = inst[14:12];
    ii = {{20{inst[31]}}, inst[31:20]};
    case (inst[6:0])
      7'h37: begin
        r.bus.op  = OP_LUI;
        r.bus.imm = {inst[31:12], 12'h0};
      end
      7'h13: if (f3 == 0) begin
        r.bus.op  = OP_ADDI;
        r.bus.imm = ii;
      end
      7'h33: if (f3 == 0 && inst[31:25] == 7'h00) r.bus.op = OP_ADD;
             else if (f3 == 0 && inst[31:25] == 7'h20) r.bus.op = OP_SUB;
      7'h03: if (f3 == 2) begin
        r.bus.op  = OP_LW;
        r.bus.imm = ii;
      end
      7'h23: if (f3 == 2) begin
        r.bus.op  = OP_SW;
        r.bus.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      7'h63: if (f3 inside {3'd0, 3'd1, 3'd4, 3'd5}) begin
        r.bus.op  = (f3 == 0) ? OP_BEQ : (f3 == 1) ? OP_BNE : (f3 == 4) ? OP_BLT : OP_BGE;
        r.bus.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      7'h6f: begin
        r.bus.op  = OP_JAL;
        r.bus.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'h67: if (f3 == 0) begin
        r.bus.op  = OP_JALR;
        r.bus.imm = ii;
      end
      default: ;
    endcase
    r.bus.gpr_wen  = r.bus.op inside {OP_LUI, OP_ADDI, OP_ADD, OP_SUB, OP_LW, OP_JAL, OP_JALR};
    r.bus.rd       = r.bus.gpr_wen ? inst[11:7] : 5'd0;
    r.bus.load_sel = (r.bus.op == OP_LW);
    r.bus.pc       = pc;
    a = operand(inst[19:15]);
    b = operand(inst[24:20]);
    r.bus.rs1_data = a;
    r.bus.rs2_data = b;
    r.stall = i_es_load && i_es_bypass.rd != 0 &&
              (i_es_bypass.rd == inst[19:15] || i_es_bypass.rd == inst[24:20]);
    r.br.target = pc + r.bus.imm;
    case (r.bus.op)
      OP_BEQ:  r.br.taken = (a == b);
      OP_BNE:  r.br.taken = (a != b);
      OP_BLT:  r.br.taken = ($signed(a) < $signed(b));
      OP_BGE:  r.br.taken = ($signed(a) >= $signed(b));
      OP_JAL:  r.br.taken = 1'b1;
      OP_JALR: begin
        r.br.taken  = 1'b1;
        r.br.target = (a + r.bus.imm) & ~32'd1;
      end
      default: r.br.taken = 1'b0;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] gen_inst(input int mode);
    logic [4:0]  rd, s1, s2;
    logic [31:0] im;
    int          k;
    k  = (mode == 4) ? 6 + rnd() % 6 : rnd() % 13;
    rd = (mode == 1) ? rnd() % 32 : rnd() % 8;
    s1 = (mode == 1) ? rnd() % 32 : rnd() % 8;
    s2 = (mode == 1) ? rnd() % 32 : rnd() % 8;
    im = rnd();
    case (k)
      0:  return {im[31:12], rd, 7'h37};
      1:  return {im[11:0], s1, 3'b000, rd, 7'h13};
      2:  return {7'h00, s2, s1, 3'b000, rd, 7'h33};
      3:  return {7'h20, s2, s1, 3'b000, rd, 7'h33};
      4:  return {im[11:0], s1, 3'b010, rd, 7'h03};
      5:  return {im[11:5], s2, s1, 3'b010, im[4:0], 7'h23};
      6, 7, 8, 9: return {im[12], im[10:5], s2, s1, (k == 6) ? 3'd0 : (k == 7) ? 3'd1 :
                          (k == 8) ? 3'd4 : 3'd5, im[4:1], im[11], 7'h63};
      10: return {im[20], im[10:1], im[11], im[19:12], rd, 7'h6f};
      11: return {im[11:0], s1, 3'b000, rd, 7'h67};
      default: return {im[31:7], 7'h7f};  // not in the subset
    endcase
  endfunction

  // small values so branch operands often compare equal
  function automatic logic [31:0] data(input int mode);
    return (mode == 4) ? rnd() % 4 - 1 : rnd();
  endfunction

  // drive at negedge and predict, update the models after posedge
  task automatic cycle(input int mode);
    ref_t r;
    if (!pend_have && rnd() % 4 != 0) begin
      pend = '{inst: gen_inst(mode), pc: next_pc};
      next_pc += 4;
      pend_have = 1'b1;
    end
    i_fs_valid   = pend_have;
    i_fs_bus     = pend_have ? pend : fs_to_ds_t'(rnd());
    i_es_allowin = (mode == 5) ? (rnd() % 3 != 0) : 1'b1;
    i_es_load    = (mode == 3) ? rnd() % 2 : 1'b0;
    i_es_bypass  = (mode inside {2, 3, 4}) ? '{rd: rnd() % 8, result: data(mode)} : '0;
    i_ms_bypass  = (mode inside {2, 4}) ? '{rd: rnd() % 8, result: data(mode)} : '0;
    i_ws_bypass  = (mode inside {2, 4}) ? '{rd: rnd() % 8, result: data(mode)} : '0;
    i_wb = '{wen: rnd() % 2, waddr: (mode == 1) ? rnd() % 32 : rnd() % 8, wdata: data(mode)};
    r = ref_model(m_bus.inst, m_bus.pc);
    exp_valid   = m_valid && !r.stall;
    exp_allowin = !m_valid || (!r.stall && i_es_allowin);
    exp_bus_en  = m_valid;
    exp_bus     = r.bus;
    exp_br      = '{taken: r.br.taken && exp_valid && i_es_allowin, target: r.br.target};
    @(posedge i_clk);
    if (i_wb.wen && i_wb.waddr != 0) shadow[i_wb.waddr] = i_wb.wdata;
    if (exp_allowin) begin
      m_valid = i_fs_valid;
      if (i_fs_valid) begin
        m_bus     = exp_br.taken ? '{inst: `NOP_INST, pc: pend.pc} : pend;
        pend_have = 1'b0;
      end
    end
    @(negedge i_clk);
  endtask

  task automatic run_test(input string name, input int mode);
    u_chk.start_test(name);
    repeat (CYCLES) cycle(mode);
    u_chk.end_test();
  endtask

  initial begin
    #((N_TESTS * CYCLES + 20) * PERIOD);
    $display("timeout: simulation did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    i_arst_n = 1'b0;
    i_fs_valid = 1'b0;
    i_fs_bus = '0;
    i_es_allowin = 1'b1;
    i_es_load = 1'b0;
    i_wb = '0;
    i_es_bypass = '0;
    i_ms_bypass = '0;
    i_ws_bypass = '0;
    exp_allowin = 1'b1;
    exp_valid = 1'b0;
    exp_bus_en = 1'b0;
    exp_bus = '0;
    exp_br = '0;
    foreach (shadow[i]) shadow[i] = '0;
    m_valid = 1'b0;
    m_bus = '0;
    pend_have = 1'b0;
    pend = '0;
    next_pc = 32'h0000_1000;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_arst_n = 1'b1;
    run_test("decode", 0);
    run_test("regread", 1);
    run_test("forward", 2);
    run_test("load_use", 3);
    run_test("branch", 4);
    run_test("backpress", 5);
    u_chk.print_totals();
    if (u_chk.err_total == 0 && u_dut.u_assert.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+.
id_pkg.sv
id_latch.sv
id_decoder.sv
id_gpr.sv
id_operand_bypass.sv
id_branch_unit.sv
id_stage.sv
id_checker.sv
id_stage_assert.sv
tb_id_stage.sv
